// ==== include/tri_cfg.svh ====
// ========================================
// triangle drawing configuration
// framebuffer size, display timing, coordinate width, queue depth
// ========================================

`ifndef TRI_CFG_SVH
`define TRI_CFG_SVH

// framebuffer in pixels
`define TRI_FB_W 32
`define TRI_FB_H 20

// horizontal timing in clocks, 48 per line
`define TRI_H_ACTIVE 32
`define TRI_H_FRONT  4
`define TRI_H_SYNC   4
`define TRI_H_BACK   8

// vertical timing in lines, 26 per frame
`define TRI_V_ACTIVE 20
`define TRI_V_FRONT  2
`define TRI_V_SYNC   2
`define TRI_V_BACK   2

// signed coordinate width
`define TRI_CORDW 8

// write queue depth, also the starting credit count
`define TRI_Q_DEPTH 8

`endif

// ==== src/tri_pkg.sv ====
// ========================================
// triangle drawing types
// coordinates, opcodes, raster states and the colour palette
// ========================================

`include "tri_cfg.svh"

package tri_pkg;

    typedef logic signed [`TRI_CORDW-1:0] coord_t;  // screen coordinate
    typedef logic [3:0] cidx_t;                      // colour index

    typedef enum logic {
        CMD_CLEAR,
        CMD_TRIANGLE
    } cmd_op_t;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_SETUP,
        RS_SCAN,
        RS_DRAIN
    } raster_state_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // 16 colour lookup, index 0 is black
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h236, 12'h725, 12'h085,
        12'hA53, 12'h555, 12'hCCC, 12'hFFE,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

endpackage

// ==== src/tri_raster.sv ====
// ========================================
// triangle rasteriser
// scans the clipped bounding box, edge test per pixel, credit-paced writes
// ========================================

`include "tri_cfg.svh"

module tri_raster (
    input  logic             clk_pix,
    input  logic             reset,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  tri_pkg::cmd_op_t cmd_op,
    input  tri_pkg::coord_t  cmd_x0,
    input  tri_pkg::coord_t  cmd_y0,
    input  tri_pkg::coord_t  cmd_x1,
    input  tri_pkg::coord_t  cmd_y1,
    input  tri_pkg::coord_t  cmd_x2,
    input  tri_pkg::coord_t  cmd_y2,
    input  tri_pkg::cidx_t   cmd_cidx,
    output logic             wr_valid,
    output tri_pkg::coord_t  wr_x,
    output tri_pkg::coord_t  wr_y,
    output tri_pkg::cidx_t   wr_cidx,
    input  logic             credit_return,
    output logic             busy
);

    localparam int EW = 2 * `TRI_CORDW + 4;            // edge function width
    localparam int CW = $clog2(`TRI_Q_DEPTH + 1);      // credit counter width
    localparam logic [CW-1:0] CRED_FULL = CW'(`TRI_Q_DEPTH);
    localparam tri_pkg::coord_t X_LAST = `TRI_FB_W - 1;
    localparam tri_pkg::coord_t Y_LAST = `TRI_FB_H - 1;

    tri_pkg::raster_state_t state;
    tri_pkg::cmd_op_t op;
    tri_pkg::coord_t vx0, vy0, vx1, vy1, vx2, vy2;   // latched vertices
    tri_pkg::cidx_t cidx;
    logic signed [`TRI_CORDW:0] dx0, dy0, dx1, dy1, dx2, dy2;  // edge deltas
    tri_pkg::coord_t x_lo, x_hi, y_hi;                // registered box
    tri_pkg::coord_t bx_min, bx_max, by_min, by_max;  // box from vertices
    tri_pkg::coord_t px, py;                          // scan position
    logic [CW-1:0] credits;
    logic signed [EW-1:0] e0, e1, e2;
    logic box_empty;
    logic hit;
    logic can_step;
    logic wr_fire;

    function automatic tri_pkg::coord_t min3(
        input tri_pkg::coord_t a,
        input tri_pkg::coord_t b,
        input tri_pkg::coord_t c
    );
        tri_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic tri_pkg::coord_t max3(
        input tri_pkg::coord_t a,
        input tri_pkg::coord_t b,
        input tri_pkg::coord_t c
    );
        tri_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // cross product of edge direction with vector to the pixel
    function automatic logic signed [EW-1:0] edge_val(
        input logic signed [`TRI_CORDW:0] ex,
        input logic signed [`TRI_CORDW:0] ey,
        input tri_pkg::coord_t ax,
        input tri_pkg::coord_t ay,
        input tri_pkg::coord_t ox,
        input tri_pkg::coord_t oy
    );
        logic signed [EW-1:0] rx;
        logic signed [EW-1:0] ry;
        rx = ax - ox;
        ry = ay - oy;
        return ex * ry - ey * rx;
    endfunction

    always_comb begin
        if (op == tri_pkg::CMD_CLEAR) begin  // whole buffer
            bx_min = '0;
            bx_max = X_LAST;
            by_min = '0;
            by_max = Y_LAST;
        end else begin
            bx_min = min3(vx0, vx1, vx2);
            bx_max = max3(vx0, vx1, vx2);
            by_min = min3(vy0, vy1, vy2);
            by_max = max3(vy0, vy1, vy2);
            if (bx_min < 0) bx_min = '0;  // clip to framebuffer
            if (by_min < 0) by_min = '0;
            if (bx_max > X_LAST) bx_max = X_LAST;
            if (by_max > Y_LAST) by_max = Y_LAST;
        end
    end

    assign box_empty = (bx_min > bx_max) || (by_min > by_max);

    assign e0 = edge_val(dx0, dy0, px, py, vx0, vy0);
    assign e1 = edge_val(dx1, dy1, px, py, vx1, vy1);
    assign e2 = edge_val(dx2, dy2, px, py, vx2, vy2);

    // inclusive edges, either winding
    assign hit = (op == tri_pkg::CMD_CLEAR)
              || (e0 >= 0 && e1 >= 0 && e2 >= 0)
              || (e0 <= 0 && e1 <= 0 && e2 <= 0);

    assign can_step = (state == tri_pkg::RS_SCAN) && (credits != '0);
    assign wr_fire  = can_step && hit;

    assign wr_valid  = wr_fire;
    assign wr_x      = px;
    assign wr_y      = py;
    assign wr_cidx   = cidx;
    assign cmd_ready = (state == tri_pkg::RS_IDLE);
    assign busy      = (state != tri_pkg::RS_IDLE);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state   <= tri_pkg::RS_IDLE;
            credits <= CRED_FULL;
        end else begin
            credits <= credits - CW'(wr_fire) + CW'(credit_return);
            case (state)
                tri_pkg::RS_IDLE: begin
                    if (cmd_valid) state <= tri_pkg::RS_SETUP;
                end
                tri_pkg::RS_SETUP: begin
                    state <= box_empty ? tri_pkg::RS_DRAIN : tri_pkg::RS_SCAN;
                end
                tri_pkg::RS_SCAN: begin
                    if (can_step && px == x_hi && py == y_hi) state <= tri_pkg::RS_DRAIN;
                end
                tri_pkg::RS_DRAIN: begin
                    if (credits == CRED_FULL) state <= tri_pkg::RS_IDLE;  // all writes landed
                end
                default: state <= tri_pkg::RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == tri_pkg::RS_IDLE && cmd_valid) begin
            op   <= cmd_op;
            vx0  <= cmd_x0;
            vy0  <= cmd_y0;
            vx1  <= cmd_x1;
            vy1  <= cmd_y1;
            vx2  <= cmd_x2;
            vy2  <= cmd_y2;
            cidx <= cmd_cidx;
        end
        if (state == tri_pkg::RS_SETUP) begin
            dx0  <= vx1 - vx0;
            dy0  <= vy1 - vy0;
            dx1  <= vx2 - vx1;
            dy1  <= vy2 - vy1;
            dx2  <= vx0 - vx2;
            dy2  <= vy0 - vy2;
            x_lo <= bx_min;
            x_hi <= bx_max;
            y_hi <= by_max;
            px   <= bx_min;
            py   <= by_min;
        end
        if (can_step) begin  // row-major walk
            if (px == x_hi) begin
                px <= x_lo;
                py <= py + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
    end

endmodule

// ==== src/pix_write_queue.sv ====
// ========================================
// pixel write queue
// FIFO of pending writes, one credit back per pop
// ========================================

`include "tri_cfg.svh"

module pix_write_queue (
    input  logic            clk_pix,
    input  logic            reset,
    input  logic            wr_valid,
    input  tri_pkg::coord_t wr_x,
    input  tri_pkg::coord_t wr_y,
    input  tri_pkg::cidx_t  wr_cidx,
    output logic            credit_return,
    output logic            q_valid,
    output tri_pkg::coord_t q_x,
    output tri_pkg::coord_t q_y,
    output tri_pkg::cidx_t  q_cidx,
    input  logic            q_pop
);

    localparam int DEPTH = `TRI_Q_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int DW    = 2 * `TRI_CORDW + 4;  // x, y and colour index

    logic [DW-1:0] mem [DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic pop;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_valid       = (count != '0);
    assign pop           = q_pop && q_valid;
    assign credit_return = pop;  // producer gets the slot back
    assign {q_x, q_y, q_cidx} = mem[rd_ptr];

    always_ff @(posedge clk_pix) begin
        if (wr_valid) mem[wr_ptr] <= {wr_x, wr_y, wr_cidx};
    end

    // credits keep the producer from pushing into a full queue
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CW'(wr_valid) - CW'(pop);
        end
    end

endmodule

// ==== src/framebuffer.sv ====
// ========================================
// colour index framebuffer
// writes queued pixels in blanking, scans out through the palette
// ========================================

`include "tri_cfg.svh"

module framebuffer (
    input  logic            clk_pix,
    input  logic            reset,
    input  tri_pkg::coord_t sx,
    input  tri_pkg::coord_t sy,
    input  logic            de,
    input  logic            hsync,
    input  logic            vsync,
    input  logic            q_valid,
    input  tri_pkg::coord_t q_x,
    input  tri_pkg::coord_t q_y,
    input  tri_pkg::cidx_t  q_cidx,
    output logic            q_pop,
    output logic [3:0]      r,
    output logic [3:0]      g,
    output logic [3:0]      b,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            de_out
);

    localparam int PIXELS = `TRI_FB_W * `TRI_FB_H;
    localparam int AW     = $clog2(PIXELS);
    localparam logic [AW-1:0] ROW = AW'(`TRI_FB_W);

    tri_pkg::cidx_t mem [PIXELS];  // undefined until first clear
    tri_pkg::cidx_t rd_cidx;
    tri_pkg::rgb_t  pix_rgb;
    logic [AW-1:0]  wr_addr, rd_addr;

    assign wr_addr = AW'(q_y) * ROW + AW'(q_x);
    assign rd_addr = AW'(sy) * ROW + AW'(sx);

    // scanout owns the memory in active video
    assign q_pop = q_valid && !de;

    always_ff @(posedge clk_pix) begin
        if (q_pop) mem[wr_addr] <= q_cidx;
        if (de) rd_cidx <= mem[rd_addr];  // 1 cycle read
    end

    // delay syncs to line up with the read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de_out    <= 1'b0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            de_out    <= de;
        end
    end

    assign pix_rgb = tri_pkg::PALETTE[rd_cidx];

    // black outside active video
    assign r = de_out ? pix_rgb.r : 4'h0;
    assign g = de_out ? pix_rgb.g : 4'h0;
    assign b = de_out ? pix_rgb.b : 4'h0;

endmodule

// ==== src/display_timing.sv ====
// ========================================
// display timing
// line and frame counters with sync, data enable and frame start
// ========================================

`include "tri_cfg.svh"

module display_timing (
    input  logic            clk_pix,
    input  logic            reset,
    output tri_pkg::coord_t sx,
    output tri_pkg::coord_t sy,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic            frame
);

    localparam int H_SYNC_S = `TRI_H_ACTIVE + `TRI_H_FRONT;
    localparam int H_SYNC_E = H_SYNC_S + `TRI_H_SYNC;
    localparam int H_LAST   = H_SYNC_E + `TRI_H_BACK - 1;
    localparam int V_SYNC_S = `TRI_V_ACTIVE + `TRI_V_FRONT;
    localparam int V_SYNC_E = V_SYNC_S + `TRI_V_SYNC;
    localparam int V_LAST   = V_SYNC_E + `TRI_V_BACK - 1;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // syncs active high
    assign hsync = (sx >= H_SYNC_S) && (sx < H_SYNC_E);
    assign vsync = (sy >= V_SYNC_S) && (sy < V_SYNC_E);
    assign de    = (sx < `TRI_H_ACTIVE) && (sy < `TRI_V_ACTIVE);
    assign frame = (sx == 0) && (sy == 0);

endmodule

// ==== src/tri_draw_top.sv ====
// ========================================
// triangle drawing subsystem
// rasteriser, write queue, framebuffer and scanout on one clock
// ========================================

module tri_draw_top (
    input  logic             clk_pix,
    input  logic             reset,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  tri_pkg::cmd_op_t cmd_op,
    input  tri_pkg::coord_t  cmd_x0,
    input  tri_pkg::coord_t  cmd_y0,
    input  tri_pkg::coord_t  cmd_x1,
    input  tri_pkg::coord_t  cmd_y1,
    input  tri_pkg::coord_t  cmd_x2,
    input  tri_pkg::coord_t  cmd_y2,
    input  tri_pkg::cidx_t   cmd_cidx,
    output logic             busy,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic [3:0]       r,
    output logic [3:0]       g,
    output logic [3:0]       b,
    output logic             frame
);

    logic wr_valid;              // raster to queue
    tri_pkg::coord_t wr_x, wr_y;
    tri_pkg::cidx_t wr_cidx;
    logic credit_return;
    logic q_valid;               // queue to framebuffer
    tri_pkg::coord_t q_x, q_y;
    tri_pkg::cidx_t q_cidx;
    logic q_pop;
    tri_pkg::coord_t sx, sy;     // scan position
    logic t_hsync, t_vsync, t_de;

    tri_raster u_raster (
        .clk_pix, .reset,
        .cmd_valid, .cmd_ready, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_x2, .cmd_y2,
        .cmd_cidx,
        .wr_valid, .wr_x, .wr_y, .wr_cidx,
        .credit_return,
        .busy
    );

    pix_write_queue u_queue (
        .clk_pix, .reset,
        .wr_valid, .wr_x, .wr_y, .wr_cidx,
        .credit_return,
        .q_valid, .q_x, .q_y, .q_cidx,
        .q_pop
    );

    framebuffer u_fb (
        .clk_pix, .reset,
        .sx, .sy,
        .de(t_de), .hsync(t_hsync), .vsync(t_vsync),
        .q_valid, .q_x, .q_y, .q_cidx, .q_pop,
        .r, .g, .b,
        .hsync_out(hsync), .vsync_out(vsync), .de_out(de)
    );

    display_timing u_timing (
        .clk_pix, .reset,
        .sx, .sy,
        .hsync(t_hsync), .vsync(t_vsync), .de(t_de),
        .frame
    );

endmodule

// ==== test/tb_tri_draw_top.sv ====
// ========================================
// testbench for the triangle drawing subsystem
// random triangles against a framebuffer model, scanout checks
// ========================================

`include "tri_cfg.svh"

module tb_tri_draw_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FB_W    = `TRI_FB_W;
    localparam int FB_H    = `TRI_FB_H;
    localparam int H_TOTAL = `TRI_H_ACTIVE + `TRI_H_FRONT + `TRI_H_SYNC + `TRI_H_BACK;
    localparam int V_TOTAL = `TRI_V_ACTIVE + `TRI_V_FRONT + `TRI_V_SYNC + `TRI_V_BACK;
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    localparam int VS_START = (`TRI_V_ACTIVE + `TRI_V_FRONT) * H_TOTAL + 1;  // registered vsync
    localparam int LIMIT   = 40 * FRAME;  // cycles allowed per command
    localparam int BP_CMDS = 6;
    localparam int N_CMDS  = 1 + 20 + BP_CMDS + 3;
    localparam int WATCHDOG_NS = (N_CMDS * 40 + 10) * FRAME * 4;

    logic clk_pix, reset, cmd_valid;
    tri_pkg::cmd_op_t cmd_op;
    tri_pkg::coord_t cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_x2, cmd_y2;
    tri_pkg::cidx_t cmd_cidx;
    logic cmd_ready, busy, hsync, vsync, de, frame;
    logic [3:0] r, g, b;

    tri_pkg::cidx_t model_fb [FB_W * FB_H];  // expected colour indices
    tri_pkg::cmd_op_t c_op;                   // next command
    int c_x [3];
    int c_y [3];
    int c_cidx;
    logic [31:0] rng = 32'd81;
    int errors, checks, tests_run, tests_failed, err_mark;

    tri_draw_top u_tri_draw_top (.*);

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not end within %0d frame periods", N_CMDS * 40 + 10);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v ^= v << 13;
        v ^= v >> 17;
        v ^= v << 5;
        return v;
    endfunction

    function automatic int rand_below(input int span);
        rng = xorshift32(rng);
        return int'(rng % span);
    endfunction

    task automatic gen_triangle(input int i);
        c_op = tri_pkg::CMD_TRIANGLE;
        for (int k = 0; k < 3; k++) begin
            c_x[k] = rand_below(40) - 4;
            c_y[k] = rand_below(28) - 4;
        end
        if (i % 5 == 3) begin  // shared vertex gives a line segment
            c_x[2] = c_x[0];
            c_y[2] = c_y[0];
        end
        if (i % 5 == 4) begin  // flat with zero area
            c_y[1] = c_y[0];
            c_y[2] = c_y[0];
        end
        c_cidx = rand_below(15) + 1;
    endtask

    // inclusive edge test inside the clipped bounding box
    task automatic apply_model();
        int e0, e1, e2;
        int x_lo, x_hi, y_lo, y_hi;
        x_lo = c_x[0];
        x_hi = c_x[0];
        y_lo = c_y[0];
        y_hi = c_y[0];
        for (int k = 1; k < 3; k++) begin
            if (c_x[k] < x_lo) x_lo = c_x[k];
            if (c_x[k] > x_hi) x_hi = c_x[k];
            if (c_y[k] < y_lo) y_lo = c_y[k];
            if (c_y[k] > y_hi) y_hi = c_y[k];
        end
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                e0 = (c_x[1] - c_x[0]) * (y - c_y[0]) - (c_y[1] - c_y[0]) * (x - c_x[0]);
                e1 = (c_x[2] - c_x[1]) * (y - c_y[1]) - (c_y[2] - c_y[1]) * (x - c_x[1]);
                e2 = (c_x[0] - c_x[2]) * (y - c_y[2]) - (c_y[0] - c_y[2]) * (x - c_x[2]);
                if (c_op == tri_pkg::CMD_CLEAR) begin
                    model_fb[y * FB_W + x] = tri_pkg::cidx_t'(c_cidx);
                end else if (x >= x_lo && x <= x_hi && y >= y_lo && y <= y_hi) begin
                    if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
                        model_fb[y * FB_W + x] = tri_pkg::cidx_t'(c_cidx);
                end
            end
        end
    endtask

    // call on a falling edge and cmd_valid stays high
    task automatic send_cmd();
        int n;
        cmd_valid = 1'b1;
        cmd_op    = c_op;
        cmd_x0    = tri_pkg::coord_t'(c_x[0]);
        cmd_y0    = tri_pkg::coord_t'(c_y[0]);
        cmd_x1    = tri_pkg::coord_t'(c_x[1]);
        cmd_y1    = tri_pkg::coord_t'(c_y[1]);
        cmd_x2    = tri_pkg::coord_t'(c_x[2]);
        cmd_y2    = tri_pkg::coord_t'(c_y[2]);
        cmd_cidx  = tri_pkg::cidx_t'(c_cidx);
        n = 0;
        while (cmd_ready !== 1'b1 && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (cmd_ready !== 1'b1) begin
            errors++;
            $display("command port never became ready, command dropped");
            return;
        end
        @(negedge clk_pix);  // transfer on the rising edge just passed
        checks++;
        if (busy !== 1'b1 || cmd_ready !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t accept: expected busy 1 ready 0, got busy %b ready %b",
                $time, busy, cmd_ready);
        end
        apply_model();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("busy stayed high for %0d cycles, draw never finished", LIMIT);
        end
    endtask

    task automatic check_sync();
        int n, de_cnt, de_runs, hs_cnt, hs_runs, vs_cnt, vs_at;
        logic prev_de, prev_hs;
        n = 0;
        while (!frame && n < 2 * FRAME) begin
            @(negedge clk_pix);
            n++;
        end
        {de_cnt, de_runs, hs_cnt, hs_runs, vs_cnt, vs_at} = '0;
        prev_de = de;
        prev_hs = hsync;
        n = 0;
        while (n == 0 || (!frame && n < 2 * FRAME)) begin
            @(negedge clk_pix);
            n++;
            de_cnt  += de;
            de_runs += (de && !prev_de);
            hs_cnt  += hsync;
            hs_runs += (hsync && !prev_hs);
            vs_cnt  += vsync;
            if (vsync && vs_at == 0) vs_at = n;
            prev_de = de;
            prev_hs = hsync;
        end
        checks++;
        if (n != FRAME) begin
            errors++;
            $display("[FAIL] %0t frame period: expected %0d, got %0d", $time, FRAME, n);
        end
        checks++;
        if (vs_at != VS_START) begin
            errors++;
            $display("[FAIL] %0t frame pulse: expected vsync %0d cycles later, got %0d",
                $time, VS_START, vs_at);
        end
        checks++;
        if (de_cnt != `TRI_H_ACTIVE * `TRI_V_ACTIVE || de_runs != `TRI_V_ACTIVE) begin
            errors++;
            $display("[FAIL] %0t de: expected %0d cycles on %0d lines, got %0d on %0d",
                $time, `TRI_H_ACTIVE * `TRI_V_ACTIVE, `TRI_V_ACTIVE, de_cnt, de_runs);
        end
        checks++;
        if (hs_cnt != `TRI_H_SYNC * V_TOTAL || hs_runs != V_TOTAL
                || vs_cnt != `TRI_V_SYNC * H_TOTAL) begin
            errors++;
            $display("[FAIL] %0t syncs: expected hsync %0d in %0d pulses vsync %0d, got %0d %0d %0d",
                $time, `TRI_H_SYNC * V_TOTAL, V_TOTAL, `TRI_V_SYNC * H_TOTAL,
                hs_cnt, hs_runs, vs_cnt);
        end
    endtask

    // one whole frame from the first active pixel
    task automatic capture_frame(input string what);
        int n, x, y;
        logic prev_de;
        tri_pkg::rgb_t exp_rgb;
        n = 0;
        while (!vsync && n < 2 * FRAME) begin
            @(negedge clk_pix);
            n++;
        end
        while ((vsync || !de) && n < 2 * FRAME) begin
            @(negedge clk_pix);
            n++;
        end
        if (n >= 2 * FRAME) begin
            errors++;
            $display("capture %s: no frame start seen on vsync and de", what);
            return;
        end
        x = 0;
        y = 0;
        prev_de = 1'b1;
        repeat (FRAME) begin
            if (de) begin
                exp_rgb = (x < FB_W && y < FB_H) ? tri_pkg::PALETTE[model_fb[y * FB_W + x]] : '0;
                checks++;
                if ({r, g, b} !== exp_rgb) begin
                    errors++;
                    $display("[FAIL] %0t %s pixel (%0d,%0d): expected %h, got %h",
                        $time, what, x, y, exp_rgb, {r, g, b});
                end
                x++;
            end else begin
                if (prev_de) begin  // line done
                    x = 0;
                    y++;
                end
                checks++;
                if ({r, g, b} !== 12'h000) begin
                    errors++;
                    $display("[FAIL] %0t %s blanking after line %0d: expected 000, got %h",
                        $time, what, y, {r, g, b});
                end
            end
            prev_de = de;
            @(negedge clk_pix);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > err_mark) begin
            tests_failed++;
            $display("test %-16s %0d errors", name, errors - err_mark);
        end else begin
            $display("test %-16s ok", name);
        end
        err_mark = errors;
    endtask

    initial begin
        {errors, checks, tests_run, tests_failed, err_mark} = '0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = tri_pkg::CMD_CLEAR;
        {cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_x2, cmd_y2} = '0;
        cmd_cidx  = '0;
        repeat (3) @(negedge clk_pix);
        checks++;
        if ({hsync, vsync, de, r, g, b, busy, cmd_ready} !== 17'h00001) begin
            errors++;
            $display("[FAIL] %0t reset: got hsync %b vsync %b de %b rgb %h busy %b ready %b",
                $time, hsync, vsync, de, {r, g, b}, busy, cmd_ready);
        end
        reset = 1'b0;
        finish_test("reset state");
        check_sync();
        finish_test("sync timing");

        c_op = tri_pkg::CMD_CLEAR;
        c_cidx = rand_below(16);
        send_cmd();
        cmd_valid = 1'b0;
        wait_idle();
        capture_frame("clear");
        finish_test("clear");

        for (int i = 0; i < 20; i++) begin
            gen_triangle(i);
            send_cmd();
            cmd_valid = 1'b0;
            wait_idle();
            capture_frame("triangle");
        end
        finish_test("triangles");

        for (int i = 0; i < BP_CMDS; i++) begin  // valid held between commands
            gen_triangle(20 + i);
            if (i == 2) c_op = tri_pkg::CMD_CLEAR;
            send_cmd();
        end
        cmd_valid = 1'b0;
        wait_idle();
        capture_frame("back to back");
        finish_test("back pressure");

        c_op = tri_pkg::CMD_CLEAR;
        c_cidx = rand_below(16);
        send_cmd();
        cmd_valid = 1'b0;
        repeat (200) @(negedge clk_pix);
        if (busy !== 1'b1) begin
            errors++;
            $display("clear finished before the reset could interrupt it");
        end
        reset = 1'b1;
        repeat (3) @(negedge clk_pix);
        checks++;
        if (busy !== 1'b0 || de !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t mid-draw reset: expected busy 0 de 0, got %b %b",
                $time, busy, de);
        end
        reset = 1'b0;
        @(negedge clk_pix);
        c_op = tri_pkg::CMD_CLEAR;
        c_cidx = rand_below(16);
        send_cmd();
        cmd_valid = 1'b0;
        wait_idle();
        gen_triangle(0);
        send_cmd();
        cmd_valid = 1'b0;
        wait_idle();
        capture_frame("after reset");
        finish_test("reset mid draw");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/tri_pkg.sv
src/tri_raster.sv
src/pix_write_queue.sv
src/framebuffer.sv
src/display_timing.sv
src/tri_draw_top.sv
test/tb_tri_draw_top.sv

// ==== Bender.yml ====
package:
  name: tri_draw

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/tri_pkg.sv
      - src/tri_raster.sv
      - src/pix_write_queue.sv
      - src/framebuffer.sv
      - src/display_timing.sv
      - src/tri_draw_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_tri_draw_top.sv
